// ==== vlog.f ====
source/dcache_pkg.sv
source/dcache_way_ram.sv
source/dcache_ctrl.sv
source/dcache_wb_buffer.sv
source/dcache_mem_port.sv
source/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module dcache_tb -f vlog.f \
		--Mdir $(OBJ_DIR) -o dcache_tb_sim

run: compile
	./$(OBJ_DIR)/dcache_tb_sim

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/dcache_tb.sv ====
`default_nettype none

module dcache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 10;
    localparam int drive_delay = 2;
    localparam int random_ops = 1480;
    // about 1500 operations and a slow miss costs well under 25 cycles
    localparam int cycle_limit = 40000;
    localparam dcache_pkg::word_t fill_key = 32'h5a5a_0000;

    typedef struct packed {
        dcache_pkg::word_t data;
        logic load;
        logic fast;
        int cycle;
    } expect_t;

    logic clk;
    logic rst;
    logic req_valid;
    dcache_pkg::addr_t req_addr;
    dcache_pkg::strb_t req_wstrb;
    dcache_pkg::word_t req_wdata;
    logic ready;
    logic data_ok;
    dcache_pkg::word_t rdata;
    logic mem_req;
    logic mem_we;
    dcache_pkg::addr_t mem_addr;
    dcache_pkg::line_t mem_wdata;
    logic mem_ready;
    logic mem_rvalid;
    dcache_pkg::line_t mem_rdata;
    logic stall_en;

    // words changed by stores keyed by word address
    dcache_pkg::word_t ref_mem[dcache_pkg::addr_t];
    // one entry per accepted request with the oldest first
    expect_t exp_q[$];
    int cycle_cnt;

    dcache_top u_dcache_top (
        .clk        (clk),
        .rst        (rst),
        .req_valid_i(req_valid),
        .req_addr_i (req_addr),
        .req_wstrb_i(req_wstrb),
        .req_wdata_i(req_wdata),
        .ready_o    (ready),
        .data_ok_o  (data_ok),
        .rdata_o    (rdata),
        .mem_req_o  (mem_req),
        .mem_we_o   (mem_we),
        .mem_addr_o (mem_addr),
        .mem_wdata_o(mem_wdata),
        .mem_ready_i(mem_ready),
        .mem_rvalid_i(mem_rvalid),
        .mem_rdata_i(mem_rdata)
    );

    dcache_mem_model u_mem_model (
        .clk         (clk),
        .rst         (rst),
        .stall_en_i  (stall_en),
        .mem_req_i   (mem_req),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_ready_o (mem_ready),
        .mem_rvalid_o(mem_rvalid),
        .mem_rdata_o (mem_rdata)
    );

    bind dcache_top dcache_checker u_dcache_checker (
        .clk        (clk),
        .rst        (rst),
        .req_valid_i(req_valid_i),
        .ready_i    (ready_o),
        .data_ok_i  (data_ok_o),
        .mem_req_i  (mem_req_o),
        .mem_we_i   (mem_we_o),
        .mem_addr_i (mem_addr_o),
        .mem_wdata_i(mem_wdata_o),
        .mem_ready_i(mem_ready_i),
        .wb_empty_i (wb_empty)
    );

    always #half_period clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            stop_with_failure("timeout: the tests did not finish within the cycle limit");
        end
    end

    function automatic dcache_pkg::word_t ref_word(input dcache_pkg::addr_t addr);
        dcache_pkg::addr_t word_addr;
        word_addr = {addr[31:2], 2'b00};
        if (ref_mem.exists(word_addr)) begin
            return ref_mem[word_addr];
        end
        return word_addr ^ fill_key;
    endfunction

    function automatic void apply_store(input dcache_pkg::addr_t addr,
                                        input dcache_pkg::strb_t strb,
                                        input dcache_pkg::word_t wdata);
        dcache_pkg::word_t word;
        word = ref_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[8*b+:8] = wdata[8*b+:8];
            end
        end
        ref_mem[{addr[31:2], 2'b00}] = word;
    endfunction

    // responses come back in acceptance order
    task automatic check_response();
        assert (exp_q.size() != 0)
        else stop_with_failure("data_ok_o pulsed with no request outstanding");
        if (exp_q[0].load) begin
            assert (rdata == exp_q[0].data)
            else report_mismatch($sformatf("load returned %h, expected %h", rdata,
                                           exp_q[0].data));
        end
        if (exp_q[0].fast) begin
            assert (cycle_cnt == exp_q[0].cycle + 1)
            else report_mismatch($sformatf("hit answered %0d cycles after acceptance",
                                           cycle_cnt - exp_q[0].cycle));
        end
        void'(exp_q.pop_front());
    endtask

    always @(negedge clk) begin
        if (!rst && data_ok) begin
            check_response();
        end
    end

    // starts and returns a short delay after a rising edge
    task automatic send(input dcache_pkg::addr_t addr, input dcache_pkg::strb_t strb,
                        input dcache_pkg::word_t wdata, input logic fast);
        expect_t item;
        req_valid = 1'b1;
        req_addr = addr;
        req_wstrb = strb;
        req_wdata = wdata;
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        item.data = ref_word(addr);
        item.load = strb == '0;
        item.fast = fast;
        item.cycle = cycle_cnt;
        exp_q.push_back(item);
        if (strb != '0) begin
            apply_store(addr, strb, wdata);
        end
        @(posedge clk);
        #drive_delay;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #drive_delay;
        end
    endtask

    task automatic miss_then_hit();
        send(32'h0000_1234, 4'b0000, '0, 1'b0);
        send(32'h0000_1234, 4'b0000, '0, 1'b1);
        wait_idle();
    endtask

    task automatic store_merge_on_hit();
        send(32'h0000_1238, 4'b0010, 32'haabb_ccdd, 1'b1);
        send(32'h0000_1238, 4'b0000, '0, 1'b1);
        send(32'h0000_1238, 4'b1100, 32'h1122_3344, 1'b1);
        send(32'h0000_1238, 4'b0000, '0, 1'b1);
        send(32'h0000_1238, 4'b1111, 32'hcafe_f00d, 1'b1);
        send(32'h0000_1238, 4'b0000, '0, 1'b1);
        wait_idle();
    endtask

    task automatic store_miss_merge();
        send(32'h0000_5674, 4'b0101, 32'h0102_0304, 1'b0);
        send(32'h0000_5674, 4'b0000, '0, 1'b1);
        wait_idle();
    endtask

    // three lines share set 0x37 in a two-way cache
    task automatic evict_and_write_back();
        dcache_pkg::addr_t line_addr[3];
        dcache_pkg::line_t stored;
        int written;
        line_addr[0] = 32'h1000_0370;
        line_addr[1] = 32'h2000_0370;
        line_addr[2] = 32'h3000_0370;
        written = 0;
        for (int i = 0; i < 3; i++) begin
            send(line_addr[i] + 32'd8, 4'b1111, 32'hd00d_0000 | i, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            send(line_addr[i] + 32'd8, 4'b0000, '0, 1'b0);
        end
        wait_idle();
        for (int i = 0; i < 3; i++) begin
            if (u_mem_model.was_written(line_addr[i])) begin
                written++;
                stored = u_mem_model.fetch_line(line_addr[i]);
                for (int k = 0; k < 4; k++) begin
                    assert (stored[k] == ref_word(line_addr[i] + 4 * k))
                    else report_mismatch($sformatf("written line %h word %0d is %h",
                                                   line_addr[i], k, stored[k]));
                end
            end
        end
        assert (written > 0)
        else stop_with_failure("no dirty line was written back to memory");
    endtask

    // a 16 KB window gives four tags per set so misses and evictions are frequent
    task automatic random_traffic();
        dcache_pkg::addr_t addr;
        dcache_pkg::strb_t strb;
        int unsigned sel;
        stall_en = 1'b1;
        for (int n = 0; n < random_ops; n++) begin
            addr = 32'h4000_0000 | ($urandom & 32'h0000_3ffc);
            sel = $urandom % 8;
            if (sel < 4) begin
                strb = 4'b0000;
            end else if (sel == 4) begin
                strb = dcache_pkg::strb_t'(1 << ($urandom % 4));
            end else if (sel == 5) begin
                strb = ($urandom % 2 != 0) ? 4'b1100 : 4'b0011;
            end else begin
                strb = 4'b1111;
            end
            send(addr, strb, $urandom, 1'b0);
        end
        wait_idle();
        stall_en = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h32d9_32ad));
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_wstrb = '0;
        req_wdata = '0;
        stall_en = 1'b0;
        cycle_cnt = 0;
        repeat (10) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        miss_then_hit();
        store_merge_on_hit();
        store_miss_merge();
        evict_and_write_back();
        random_traffic();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/dcache_checker.sv ====
`default_nettype none

// protocol properties of the cache top level
module dcache_checker (
    input logic clk,
    input logic rst,
    input logic req_valid_i,
    input logic ready_i,
    input logic data_ok_i,
    input logic mem_req_i,
    input logic mem_we_i,
    input dcache_pkg::addr_t mem_addr_i,
    input dcache_pkg::line_t mem_wdata_i,
    input logic mem_ready_i,
    input logic wb_empty_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // accepted requests still waiting for data_ok
    logic [1:0] pending_q;
    logic accept;

    assign accept = req_valid_i && ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= '0;
        end else if (accept && !data_ok_i) begin
            pending_q <= pending_q + 2'd1;
        end else if (data_ok_i && !accept) begin
            pending_q <= pending_q - 2'd1;
        end
    end

    hold_until_accept: assert property (@(posedge clk) disable iff (rst)
        mem_req_i && !mem_ready_i |=> mem_req_i && $stable(mem_we_i)
            && $stable(mem_addr_i) && $stable(mem_wdata_i))
        else $error("memory request changed before it was accepted");

    read_after_drain: assert property (@(posedge clk) disable iff (rst)
        mem_req_i && mem_ready_i && !mem_we_i |-> wb_empty_i)
        else $error("refill read accepted while the write-back buffer holds lines");

    response_has_request: assert property (@(posedge clk) disable iff (rst)
        data_ok_i |-> pending_q != 2'd0)
        else $error("data_ok_o without an outstanding request");

endmodule

`default_nettype wire

// ==== verification/dcache_mem_model.sv ====
`default_nettype none

// line-wide memory behind the cache, answers reads after a short random delay
module dcache_mem_model (
    input logic clk,
    input logic rst,
    input logic stall_en_i,

    input logic mem_req_i,
    input logic mem_we_i,
    input dcache_pkg::addr_t mem_addr_i,
    input dcache_pkg::line_t mem_wdata_i,
    output logic mem_ready_o,
    output logic mem_rvalid_o,
    output dcache_pkg::line_t mem_rdata_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // only lines that were written back are stored
    dcache_pkg::line_t lines[dcache_pkg::addr_t];

    logic read_pend_q;
    logic [1:0] read_wait_q;
    dcache_pkg::addr_t read_addr_q;

    function automatic logic was_written(input dcache_pkg::addr_t line_addr);
        return lines.exists(line_addr);
    endfunction

    // untouched memory holds each word address xor a fixed key
    function automatic dcache_pkg::line_t fetch_line(input dcache_pkg::addr_t line_addr);
        dcache_pkg::line_t line;
        if (lines.exists(line_addr)) begin
            line = lines[line_addr];
        end else begin
            for (int i = 0; i < 4; i++) begin
                line[i] = (line_addr + dcache_pkg::addr_t'(4 * i)) ^ 32'h5a5a_0000;
            end
        end
        return line;
    endfunction

    always @(posedge clk) begin
        mem_rvalid_o <= 1'b0;
        if (rst) begin
            mem_ready_o <= 1'b0;
            read_pend_q <= 1'b0;
        end else begin
            // a stall cycle about one time in four
            mem_ready_o <= !stall_en_i || ($urandom % 4 != 0);
            if (mem_req_i && mem_ready_o) begin
                if (mem_we_i) begin
                    lines[mem_addr_i] = mem_wdata_i;
                end else begin
                    read_pend_q <= 1'b1;
                    read_addr_q <= mem_addr_i;
                    read_wait_q <= 2'($urandom % 3);
                end
            end
            if (read_pend_q) begin
                if (read_wait_q == 2'd0) begin
                    mem_rvalid_o <= 1'b1;
                    mem_rdata_o <= fetch_line(read_addr_q);
                    read_pend_q <= 1'b0;
                end else begin
                    read_wait_q <= read_wait_q - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`default_nettype none

module dcache_top (
    input logic clk,
    input logic rst,

    // cpu side
    input logic req_valid_i,
    input dcache_pkg::addr_t req_addr_i,
    input dcache_pkg::strb_t req_wstrb_i,
    input dcache_pkg::word_t req_wdata_i,
    output logic ready_o,
    output logic data_ok_o,
    output dcache_pkg::word_t rdata_o,

    // memory side
    output logic mem_req_o,
    output logic mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::line_t mem_wdata_o,
    input logic mem_ready_i,
    input logic mem_rvalid_i,
    input dcache_pkg::line_t mem_rdata_i
);

    dcache_pkg::index_t [dcache_pkg::num_ways-1:0] tag_raddr;
    dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0] tag_rdata;
    logic [dcache_pkg::num_ways-1:0] tag_we;
    dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0] tag_wdata;
    dcache_pkg::index_t [dcache_pkg::num_ways-1:0] line_raddr;
    dcache_pkg::line_t [dcache_pkg::num_ways-1:0] line_rdata;
    logic [dcache_pkg::num_ways-1:0] line_we;
    dcache_pkg::line_t [dcache_pkg::num_ways-1:0] line_wdata;
    dcache_pkg::index_t [dcache_pkg::num_ways-1:0] waddr;

    logic wb_push;
    dcache_pkg::addr_t wb_addr;
    dcache_pkg::line_t wb_line;
    logic wb_full;
    logic wb_empty;
    dcache_pkg::addr_t wb_head_addr;
    dcache_pkg::line_t wb_head_line;
    logic wb_pop;

    logic refill_req;
    dcache_pkg::addr_t refill_addr;
    logic refill_done;
    dcache_pkg::line_t refill_line;

    dcache_ctrl u_dcache_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_wstrb_i  (req_wstrb_i),
        .req_wdata_i  (req_wdata_i),
        .ready_o      (ready_o),
        .data_ok_o    (data_ok_o),
        .rdata_o      (rdata_o),
        .tag_raddr_o  (tag_raddr),
        .tag_rdata_i  (tag_rdata),
        .tag_we_o     (tag_we),
        .tag_wdata_o  (tag_wdata),
        .line_raddr_o (line_raddr),
        .line_rdata_i (line_rdata),
        .line_we_o    (line_we),
        .line_wdata_o (line_wdata),
        .waddr_o      (waddr),
        .wb_push_o    (wb_push),
        .wb_addr_o    (wb_addr),
        .wb_line_o    (wb_line),
        .wb_full_i    (wb_full),
        .refill_req_o (refill_req),
        .refill_addr_o(refill_addr),
        .refill_done_i(refill_done),
        .refill_line_i(refill_line)
    );

    // a tag ram and a data ram for every way
    for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : g_way
        dcache_way_ram #(
            .entry_t(dcache_pkg::tag_entry_t)
        ) u_tag_ram (
            .clk    (clk),
            .raddr_i(tag_raddr[w]),
            .rdata_o(tag_rdata[w]),
            .we_i   (tag_we[w]),
            .waddr_i(waddr[w]),
            .wdata_i(tag_wdata[w])
        );

        dcache_way_ram #(
            .entry_t(dcache_pkg::line_t)
        ) u_line_ram (
            .clk    (clk),
            .raddr_i(line_raddr[w]),
            .rdata_o(line_rdata[w]),
            .we_i   (line_we[w]),
            .waddr_i(waddr[w]),
            .wdata_i(line_wdata[w])
        );
    end

    dcache_wb_buffer u_dcache_wb_buffer (
        .clk        (clk),
        .rst        (rst),
        .push_i     (wb_push),
        .push_addr_i(wb_addr),
        .push_line_i(wb_line),
        .full_o     (wb_full),
        .empty_o    (wb_empty),
        .head_addr_o(wb_head_addr),
        .head_line_o(wb_head_line),
        .pop_i      (wb_pop)
    );

    dcache_mem_port u_dcache_mem_port (
        .clk          (clk),
        .rst          (rst),
        .wb_empty_i   (wb_empty),
        .wb_addr_i    (wb_head_addr),
        .wb_line_i    (wb_head_line),
        .wb_pop_o     (wb_pop),
        .refill_req_i (refill_req),
        .refill_addr_i(refill_addr),
        .refill_done_o(refill_done),
        .refill_line_o(refill_line),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ready_i  (mem_ready_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

endmodule

`default_nettype wire

// ==== source/dcache_mem_port.sv ====
`default_nettype none

module dcache_mem_port (
    input logic clk,
    input logic rst,

    // write-back buffer head
    input logic wb_empty_i,
    input dcache_pkg::addr_t wb_addr_i,
    input dcache_pkg::line_t wb_line_i,
    output logic wb_pop_o,

    // refill from the controller
    input logic refill_req_i,
    input dcache_pkg::addr_t refill_addr_i,
    output logic refill_done_o,
    output dcache_pkg::line_t refill_line_o,

    // line-wide memory bus
    output logic mem_req_o,
    output logic mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::line_t mem_wdata_o,
    input logic mem_ready_i,
    input logic mem_rvalid_i,
    input dcache_pkg::line_t mem_rdata_i
);

    typedef enum logic [1:0] {
        port_idle,
        port_write,
        port_read,
        port_wait
    } port_state_t;

    port_state_t state_q;

    assign wb_pop_o = state_q == port_write && mem_ready_i;
    assign refill_done_o = state_q == port_wait && mem_rvalid_i;
    assign refill_line_o = mem_rdata_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= port_idle;
            mem_req_o <= 1'b0;
        end else begin
            case (state_q)
                port_idle: begin
                    // drains go first, a read only starts on an empty buffer
                    if (!wb_empty_i) begin
                        state_q <= port_write;
                        mem_req_o <= 1'b1;
                    end else if (refill_req_i) begin
                        state_q <= port_read;
                        mem_req_o <= 1'b1;
                    end
                end
                port_write: begin
                    if (mem_ready_i) begin
                        state_q <= port_idle;
                        mem_req_o <= 1'b0;
                    end
                end
                port_read: begin
                    if (mem_ready_i) begin
                        state_q <= port_wait;
                        mem_req_o <= 1'b0;
                    end
                end
                port_wait: begin
                    if (mem_rvalid_i) begin
                        state_q <= port_idle;
                    end
                end
                default: state_q <= port_idle;
            endcase
        end
    end

    // request fields only move while idle, so they hold until acceptance
    always_ff @(posedge clk) begin
        if (state_q == port_idle) begin
            mem_we_o <= !wb_empty_i;
            mem_addr_o <= wb_empty_i ? refill_addr_i : wb_addr_i;
            mem_wdata_o <= wb_line_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_wb_buffer.sv ====
`default_nettype none

module dcache_wb_buffer (
    input logic clk,
    input logic rst,

    // victim lines from the controller
    input logic push_i,
    input dcache_pkg::addr_t push_addr_i,
    input dcache_pkg::line_t push_line_i,
    output logic full_o,
    output logic empty_o,

    // oldest entry towards the memory port
    output dcache_pkg::addr_t head_addr_o,
    output dcache_pkg::line_t head_line_o,
    input logic pop_i
);

    localparam int ptr_width = $clog2(dcache_pkg::wb_depth);

    dcache_pkg::addr_t addr_q[dcache_pkg::wb_depth];
    dcache_pkg::line_t line_q[dcache_pkg::wb_depth];
    logic [ptr_width-1:0] wr_ptr_q;
    logic [ptr_width-1:0] rd_ptr_q;
    logic [ptr_width:0] count_q;
    logic do_push;
    logic do_pop;

    assign full_o = count_q == (ptr_width + 1)'(dcache_pkg::wb_depth);
    assign empty_o = count_q == '0;
    assign do_push = push_i && !full_o;
    assign do_pop = pop_i && !empty_o;

    assign head_addr_o = addr_q[rd_ptr_q];
    assign head_line_o = line_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_q[wr_ptr_q] <= push_addr_i;
            line_q[wr_ptr_q] <= push_line_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop in one cycle leave the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl (
    input logic clk,
    input logic rst,

    // cpu request
    input logic req_valid_i,
    input dcache_pkg::addr_t req_addr_i,
    input dcache_pkg::strb_t req_wstrb_i,
    input dcache_pkg::word_t req_wdata_i,

    // cpu response
    output logic ready_o,
    output logic data_ok_o,
    output dcache_pkg::word_t rdata_o,

    // way rams, one slot per way
    output dcache_pkg::index_t [dcache_pkg::num_ways-1:0] tag_raddr_o,
    input dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0] tag_rdata_i,
    output logic [dcache_pkg::num_ways-1:0] tag_we_o,
    output dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0] tag_wdata_o,
    output dcache_pkg::index_t [dcache_pkg::num_ways-1:0] line_raddr_o,
    input dcache_pkg::line_t [dcache_pkg::num_ways-1:0] line_rdata_i,
    output logic [dcache_pkg::num_ways-1:0] line_we_o,
    output dcache_pkg::line_t [dcache_pkg::num_ways-1:0] line_wdata_o,
    output dcache_pkg::index_t [dcache_pkg::num_ways-1:0] waddr_o,

    // write-back buffer
    output logic wb_push_o,
    output dcache_pkg::addr_t wb_addr_o,
    output dcache_pkg::line_t wb_line_o,
    input logic wb_full_i,

    // refill through the memory port
    output logic refill_req_o,
    output dcache_pkg::addr_t refill_addr_o,
    input logic refill_done_i,
    input dcache_pkg::line_t refill_line_i
);

    localparam int off_lsb = dcache_pkg::offset_width;
    localparam int tag_lsb = off_lsb + dcache_pkg::index_width;

    typedef enum logic [1:0] {
        st_clear,
        st_idle,
        st_evict,
        st_refill
    } state_t;

    state_t state_q, state_d;
    dcache_pkg::index_t clr_cnt_q;
    logic [dcache_pkg::lfsr_width-1:0] lfsr_q;
    logic victim_q;

    // lookup stage
    logic p2_valid_q;
    dcache_pkg::addr_t p2_addr_q;
    dcache_pkg::strb_t p2_wstrb_q;
    dcache_pkg::word_t p2_wdata_q;

    dcache_pkg::tag_t p2_tag;
    dcache_pkg::index_t p2_index;
    logic [off_lsb-3:0] p2_word;
    logic p2_store;
    logic accept;
    logic [dcache_pkg::num_ways-1:0] hit_way;
    logic hit;
    logic store_hit;
    logic refill_write;
    logic victim_dirty;
    dcache_pkg::line_t hit_line;
    dcache_pkg::line_t base_line;
    dcache_pkg::tag_entry_t wr_entry;
    dcache_pkg::line_t wr_line;

    // replaces the strobed bytes of one word in a line
    function automatic dcache_pkg::line_t merge_store(
        input dcache_pkg::line_t line,
        input logic [off_lsb-3:0] word_sel,
        input dcache_pkg::strb_t strb,
        input dcache_pkg::word_t wdata
    );
        dcache_pkg::line_t merged;
        merged = line;
        for (int b = 0; b < dcache_pkg::word_width / 8; b++) begin
            if (strb[b]) begin
                merged[word_sel][8*b+:8] = wdata[8*b+:8];
            end
        end
        return merged;
    endfunction

    assign p2_tag = p2_addr_q[tag_lsb+:dcache_pkg::tag_width];
    assign p2_index = p2_addr_q[off_lsb+:dcache_pkg::index_width];
    assign p2_word = p2_addr_q[off_lsb-1:2];
    assign p2_store = p2_wstrb_q != '0;

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            hit_way[w] = tag_rdata_i[w].valid && tag_rdata_i[w].tag == p2_tag;
            if (hit_way[w]) begin
                hit_line = line_rdata_i[w];
            end
        end
    end

    assign hit = p2_valid_q && (hit_way != '0);
    assign store_hit = state_q == st_idle && hit && p2_store;
    assign refill_write = state_q == st_refill && refill_done_i;

    // a store or a miss in the lookup stage blocks the next request
    assign ready_o = state_q == st_idle && !(p2_valid_q && (p2_store || !hit));
    assign accept = req_valid_i && ready_o;

    assign data_ok_o = (state_q == st_idle && hit) || refill_write;
    assign base_line = (state_q == st_refill) ? refill_line_i : hit_line;
    assign rdata_o = base_line[p2_word];

    // refill lines come back with the pending store already merged
    assign wr_line = merge_store(base_line, p2_word, p2_wstrb_q, p2_wdata_q);
    always_comb begin
        wr_entry = '0;
        if (state_q != st_clear) begin
            wr_entry = '{dirty: p2_store, valid: 1'b1, tag: p2_tag};
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            // keep reading the held set so victim data stays put during a miss
            tag_raddr_o[w] = accept ? req_addr_i[off_lsb+:dcache_pkg::index_width] : p2_index;
            line_raddr_o[w] = tag_raddr_o[w];
            waddr_o[w] = (state_q == st_clear) ? clr_cnt_q : p2_index;
            tag_wdata_o[w] = wr_entry;
            line_wdata_o[w] = wr_line;
            line_we_o[w] = (store_hit && hit_way[w]) || (refill_write && w == int'(victim_q));
            tag_we_o[w] = state_q == st_clear || line_we_o[w];
        end
    end

    // victim handling
    assign victim_dirty = tag_rdata_i[victim_q].valid && tag_rdata_i[victim_q].dirty;
    assign wb_push_o = state_q == st_evict && victim_dirty && !wb_full_i;
    assign wb_addr_o = {tag_rdata_i[victim_q].tag, p2_index, {off_lsb{1'b0}}};
    assign wb_line_o = line_rdata_i[victim_q];

    assign refill_req_o = state_q == st_refill;
    assign refill_addr_o = {p2_addr_q[dcache_pkg::addr_width-1:off_lsb], {off_lsb{1'b0}}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_clear: begin
                if (clr_cnt_q == '1) begin
                    state_d = st_idle;
                end
            end
            st_idle: begin
                if (p2_valid_q && !hit) begin
                    state_d = st_evict;
                end
            end
            st_evict: begin
                // a full buffer holds the dirty victim here
                if (!victim_dirty || !wb_full_i) begin
                    state_d = st_refill;
                end
            end
            st_refill: begin
                if (refill_done_i) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_clear;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_clear;
            clr_cnt_q <= '0;
            p2_valid_q <= 1'b0;
            lfsr_q <= dcache_pkg::lfsr_width'(1);
        end else begin
            state_q <= state_d;
            if (state_q == st_clear) begin
                clr_cnt_q <= clr_cnt_q + 1'b1;
            end
            if (accept) begin
                p2_valid_q <= 1'b1;
            end else if (data_ok_o) begin
                p2_valid_q <= 1'b0;
            end
            // x^16 + x^14 + x^13 + x^11 + 1
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            p2_addr_q <= req_addr_i;
            p2_wstrb_q <= req_wstrb_i;
            p2_wdata_q <= req_wdata_i;
        end
        // the way is chosen once per miss
        if (state_q == st_idle) begin
            victim_q <= lfsr_q[0];
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_way_ram.sv ====
`default_nettype none

// one way of the cache, used for both tag entries and data lines
module dcache_way_ram #(
    parameter type entry_t = logic
) (
    input logic clk,

    // read port, data appears one cycle after the address
    input dcache_pkg::index_t raddr_i,
    output entry_t rdata_o,

    // write port
    input logic we_i,
    input dcache_pkg::index_t waddr_i,
    input entry_t wdata_i
);

    entry_t mem[dcache_pkg::num_sets];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // address and data widths
    localparam int addr_width = 32;
    localparam int word_width = 32;

    // line geometry
    localparam int line_bytes = 16;
    localparam int line_width = line_bytes * 8;

    // set-associative organisation
    localparam int num_ways = 2;
    localparam int num_sets = 256;

    // address split: tag | index | offset
    localparam int offset_width = $clog2(line_bytes);
    localparam int index_width = $clog2(num_sets);
    localparam int tag_width = addr_width - index_width - offset_width;

    // dirty victim lines waiting for the memory bus
    localparam int wb_depth = 4;

    // replacement lfsr
    localparam int lfsr_width = 16;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [word_width-1:0] word_t;

    // all-zero strobe marks a load
    typedef logic [word_width/8-1:0] strb_t;

    typedef logic [index_width-1:0] index_t;
    typedef logic [tag_width-1:0] tag_t;
    typedef word_t [line_width/word_width-1:0] line_t;

    typedef struct packed {
        logic dirty;
        logic valid;
        tag_t tag;
    } tag_entry_t;

endpackage

`default_nettype wire
